/* tb.f */
verilog/gnn_weight_pkg.sv
verilog/weight_sram.sv
verilog/weight_cntl.sv
verilog/vertex_mac.sv
verilog/weight_stream_top.sv
bench/weight_stream_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the weight stream testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f tb.f \
    --top-module weight_stream_tb \
    -o weight_stream_sim

output=$(./obj_dir/weight_stream_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "TEST PASSED"; then
    exit 0
else
    exit 1
fi

/* bench/weight_stream_tb.sv */
`timescale 1ns/1ps

module weight_stream_tb
    import gnn_weight_pkg::*;
();

    localparam int clk_half = 20;
    localparam int wait_limit = 100;
    localparam int quiet_cycles = 20;

    logic clk;
    logic reset;
    logic wr_en;
    logic [sram_aw-1:0] wr_addr;
    logic [word_w-1:0] wr_data;
    logic fire;
    run_cfg_t cfg;
    feature_vec_t features;
    logic idle;
    logic result_valid;
    layer_result_t result;
    logic done;

    // reference copy of the weight sram, address is {layer, line}
    logic [word_w-1:0] model_mem [sram_depth];
    logic [15:0] lfsr_state;

    weight_stream_top weight_stream_top_i (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .fire         (fire),
        .cfg          (cfg),
        .features     (features),
        .idle         (idle),
        .result_valid (result_valid),
        .result       (result),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic feature_vec_t random_features();
        feature_vec_t f;
        logic [31:0] bits;
        f = '0;
        for (int i = 0; i < max_fv_num; i++) begin
            bits = take_bits(fv_size);
            f = {f[max_fv_num-2:0], bits[fv_size-1:0]};
        end
        return f;
    endfunction

    // dot product of the features with one layer of the model
    function automatic logic [acc_w-1:0] expected_sum(
        input logic [layer_w-1:0] layer,
        input logic [fv_idx_w:0] num_fv,
        input feature_vec_t f
    );
        logic [acc_w-1:0] sum;
        logic [2*fv_size-1:0] prod;
        logic [fv_size-1:0] w;
        logic [sram_aw-1:0] addr;
        logic [fv_idx_w:0] i;
        sum = '0;
        for (i = '0; i < num_fv; i++) begin
            // weight i sits in line i/2, byte i mod 2
            addr = {layer, i[fv_idx_w-1:1]};
            w = i[0] ? model_mem[addr][2*fv_size-1:fv_size] : model_mem[addr][fv_size-1:0];
            prod = {{fv_size{1'b0}}, f[i[fv_idx_w-1:0]]} * {{fv_size{1'b0}}, w};
            sum = sum + {{(acc_w-2*fv_size){1'b0}}, prod};
        end
        return sum;
    endfunction

    task automatic abort_run(input string why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_result(input string name, input layer_result_t got,
                                input layer_result_t want);
        if (got !== want) begin
            $display("mismatch at %0t: %s got layer %0d sum %0d, expected layer %0d sum %0d",
                     $time, name, got.layer, got.sum, want.layer, want.sum);
            abort_run("layer result differs from the reference model");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, want);
            abort_run("status flag differs from the expected value");
        end
    endtask

    task automatic wait_for_idle(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (idle !== 1'b1) begin
            n++;
            if (n > limit) begin
                $display("timeout: idle did not come back within %0d cycles", limit);
                abort_run("controller never returned to idle");
            end
            @(negedge clk);
        end
    endtask

    // done must never show up without a result
    task automatic wait_for_result(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (result_valid !== 1'b1) begin
            check_flag("done", done, 1'b0);
            n++;
            if (n > limit) begin
                $display("timeout: no layer result within %0d cycles", limit);
                abort_run("expected layer result never arrived");
            end
            @(negedge clk);
        end
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_flag("result_valid", result_valid, 1'b0);
            check_flag("done", done, 1'b0);
        end
    endtask

    task automatic load_word(input logic [sram_aw-1:0] addr, input logic [word_w-1:0] data);
        @(posedge clk);
        wr_en <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        model_mem[addr] = data;
    endtask

    task automatic load_all_words();
        logic [31:0] bits;
        for (int a = 0; a < sram_depth; a++) begin
            bits = take_bits(word_w);
            load_word(a[sram_aw-1:0], bits[word_w-1:0]);
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic reload_words(input int count);
        logic [31:0] bits;
        repeat (count) begin
            bits = take_bits(sram_aw + word_w);
            load_word(bits[sram_aw+word_w-1:word_w], bits[word_w-1:0]);
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    // one run, optionally with a stray fire and write while busy
    task automatic run_layers(input logic [layer_w-1:0] nl_m1,
                              input logic [fv_idx_w:0] num_fv,
                              input bit disturb);
        logic [acc_w-1:0] exp_sum [max_num_weight_layer];
        feature_vec_t fv;
        run_cfg_t run_cfg;
        run_cfg_t bad_cfg;
        layer_result_t want;
        logic [sram_aw-1:0] bad_addr;
        logic [31:0] bits;
        logic [layer_w-1:0] l;
        wait_for_idle(wait_limit);
        fv = random_features();
        run_cfg.num_layer_m1 = nl_m1;
        run_cfg.num_fv = num_fv;
        for (int k = 0; k <= int'(nl_m1); k++) begin
            l = k[layer_w-1:0];
            exp_sum[l] = expected_sum(l, num_fv, fv);
        end
        @(posedge clk);
        fire <= 1'b1;
        cfg <= run_cfg;
        features <= fv;
        @(posedge clk);
        fire <= 1'b0;
        if (disturb) begin
            @(negedge clk);
            check_flag("idle", idle, 1'b0);
            // aim at the last layer, which is read well after this point
            bits = take_bits(sram_aw - layer_w);
            bad_addr = {nl_m1, bits[sram_aw-layer_w-1:0]};
            bad_cfg.num_layer_m1 = ~nl_m1;
            bad_cfg.num_fv = num_fv;
            @(posedge clk);
            fire <= 1'b1;
            cfg <= bad_cfg;
            features <= random_features();
            wr_en <= 1'b1;
            wr_addr <= bad_addr;
            wr_data <= ~model_mem[bad_addr];
            @(posedge clk);
            fire <= 1'b0;
            wr_en <= 1'b0;
        end
        for (int k = 0; k <= int'(nl_m1); k++) begin
            l = k[layer_w-1:0];
            wait_for_result(wait_limit);
            want.layer = l;
            want.sum = exp_sum[l];
            check_result("result", result, want);
            check_flag("done", done, l == nl_m1);
        end
        check_quiet(quiet_cycles);
        wait_for_idle(wait_limit);
    endtask

    initial begin
        logic [31:0] bits;
        logic [fv_idx_w:0] fv_len;
        lfsr_state = 16'd94;
        reset <= 1'b0;
        wr_en <= 1'b0;
        wr_addr <= '0;
        wr_data <= '0;
        fire <= 1'b0;
        cfg <= '0;
        features <= '0;
        repeat (10) @(posedge clk);
        reset <= 1'b1;

        // out of reset the engine sits idle and silent
        repeat (8) begin
            @(negedge clk);
            check_flag("idle", idle, 1'b1);
            check_flag("result_valid", result_valid, 1'b0);
            check_flag("done", done, 1'b0);
        end

        // full memory, full size run
        load_all_words();
        run_layers(2'd3, 5'd16, 1'b0);

        // random shapes, num_fv even from 2 to 16
        repeat (6) begin
            bits = take_bits(layer_w + 3);
            fv_len = {1'b0, bits[2:0], 1'b0} + 5'd2;
            run_layers(bits[4:3], fv_len, 1'b0);
        end

        // stray fire and write while busy
        run_layers(2'd3, 5'd16, 1'b1);

        // a few new weights between runs
        reload_words(4);
        run_layers(2'd3, 5'd16, 1'b0);
        bits = take_bits(layer_w + 3);
        fv_len = {1'b0, bits[2:0], 1'b0} + 5'd2;
        run_layers(bits[4:3], fv_len, 1'b0);

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* verilog/weight_stream_top.sv */
`timescale 1ns/1ps

module weight_stream_top
    import gnn_weight_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               wr_en,
    input  logic [sram_aw-1:0] wr_addr,
    input  logic [word_w-1:0]  wr_data,
    input  logic               fire,
    input  run_cfg_t           cfg,
    input  feature_vec_t       features,
    output logic               idle,
    output logic               result_valid,
    output layer_result_t      result,
    output logic               done
);

    sram_req_t load_req;
    sram_req_t cntl_req;
    sram_req_t sram_req;
    weight_word_t rdata;
    weight_beat_t beat;
    logic fire_ok;

    // a fire during a run is dropped
    assign fire_ok = fire && idle;

    always_comb begin
        load_req.cen = !wr_en;
        load_req.wen = 1'b0;
        load_req.addr = wr_addr;
        load_req.wdata.raw = wr_data;
    end

    // loader owns the port only while idle, so writes during a run vanish
    assign sram_req = idle ? load_req : cntl_req;

    weight_sram weight_sram_i (
        .clk   (clk),
        .req   (sram_req),
        .rdata (rdata)
    );

    weight_cntl weight_cntl_i (
        .clk      (clk),
        .reset    (reset),
        .fire     (fire_ok),
        .cfg      (cfg),
        .idle     (idle),
        .sram_req (cntl_req),
        .rdata    (rdata),
        .beat     (beat)
    );

    vertex_mac vertex_mac_i (
        .clk          (clk),
        .reset        (reset),
        .fire         (fire_ok),
        .features     (features),
        .beat         (beat),
        .result_valid (result_valid),
        .result       (result),
        .done         (done)
    );

endmodule

/* verilog/vertex_mac.sv */
`timescale 1ns/1ps

module vertex_mac
    import gnn_weight_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          fire,
    input  feature_vec_t  features,
    input  weight_beat_t  beat,
    output logic          result_valid,
    output layer_result_t result,
    output logic          done
);

    feature_vec_t features_q;

    logic [fv_idx_w-1:0] idx_1;
    logic [2*fv_size-1:0] prod_0;
    logic [2*fv_size-1:0] prod_1;

    logic [acc_w-1:0] acc;
    logic [acc_w-1:0] acc_base;
    logic [acc_w-1:0] acc_nx;

    logic [layer_w-1:0] layer_cnt;
    logic [layer_w-1:0] cur_layer;
    logic after_change;

    // feature vector stays put for the whole run
    always_ff @(posedge clk) begin
        if (fire) begin
            features_q <= features;
        end
    end

    // fv_idx is even, so +1 never wraps
    assign idx_1 = beat.fv_idx + 1'b1;
    assign prod_0 = beat.weights.w[0] * features_q[beat.fv_idx];
    assign prod_1 = beat.weights.w[1] * features_q[idx_1];

    // fresh sum at start of run or after a layer boundary
    assign acc_base = (beat.sos || after_change) ? '0 : acc;
    assign acc_nx = acc_base + prod_0 + prod_1;

    assign cur_layer = beat.sos ? '0 : layer_cnt;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            result_valid <= 1'b0;
            done <= 1'b0;
            after_change <= 1'b0;
            layer_cnt <= '0;
        end else begin
            result_valid <= beat.valid && beat.change;
            done <= beat.valid && beat.eos;
            if (beat.valid) begin
                after_change <= beat.change;
                if (beat.change) begin
                    layer_cnt <= cur_layer + 1'b1;
                end else begin
                    layer_cnt <= cur_layer;
                end
            end
        end
    end

    // accumulator and result payload
    always_ff @(posedge clk) begin
        if (beat.valid) begin
            acc <= acc_nx;
        end
        if (beat.valid && beat.change) begin
            result.sum <= acc_nx;
            result.layer <= cur_layer;
        end
    end

endmodule

/* verilog/weight_cntl.sv */
`timescale 1ns/1ps

module weight_cntl
    import gnn_weight_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         fire,
    input  run_cfg_t     cfg,
    output logic         idle,
    output sram_req_t    sram_req,
    input  weight_word_t rdata,
    output weight_beat_t beat
);

    typedef enum logic {
        st_idle,
        st_work
    } state_t;

    state_t state;
    state_t state_nx;

    run_cfg_t cfg_q;

    logic [layer_w-1:0] layer_cnt;
    logic [layer_w-1:0] layer_nx;
    logic [line_w-1:0] line_cnt;
    logic [line_w-1:0] line_nx;
    logic idle_nx;

    logic [line_w:0] line_inc;
    logic last_line;
    logic last_layer;

    // markers of the read issued this cycle, then one stage to meet rdata
    weight_beat_t rd_mark;
    weight_beat_t mark_q;
    weight_beat_t beat_nx;

    // run parameters, held for the whole run
    always_ff @(posedge clk) begin
        if (state == st_idle && fire) begin
            cfg_q <= cfg;
        end
    end

    // num_fv is even, so a layer spans num_fv/2 lines
    assign line_inc = {1'b0, line_cnt} + 1'b1;
    assign last_line = line_inc == cfg_q.num_fv[fv_idx_w:1];
    assign last_layer = layer_cnt == cfg_q.num_layer_m1;

    // read request straight from the counters, port parked while idle
    always_comb begin
        sram_req = '0;
        sram_req.cen = 1'b1;
        sram_req.wen = 1'b1;
        if (state == st_work) begin
            sram_req.cen = 1'b0;
            sram_req.addr = {layer_cnt, line_cnt};
        end
    end

    always_comb begin
        rd_mark = '0;
        if (state == st_work) begin
            rd_mark.valid = 1'b1;
            // first read overall
            rd_mark.sos = (layer_cnt == '0) && (line_cnt == '0);
            rd_mark.change = last_line;
            rd_mark.eos = last_line && last_layer;
            // two weights per line
            rd_mark.fv_idx = {line_cnt, 1'b0};
        end
    end

    // next state and counters
    always_comb begin
        state_nx = state;
        layer_nx = layer_cnt;
        line_nx = line_cnt;
        idle_nx = idle;
        case (state)
            st_idle: begin
                if (fire) begin
                    state_nx = st_work;
                    idle_nx = 1'b0;
                end
            end
            st_work: begin
                if (last_line) begin
                    line_nx = '0;
                    layer_nx = layer_cnt + 1'b1;
                end else begin
                    line_nx = line_inc[line_w-1:0];
                end
                // last read of the run, port is free from next cycle
                if (last_line && last_layer) begin
                    state_nx = st_idle;
                    layer_nx = '0;
                    idle_nx = 1'b1;
                end
            end
            default: begin
                state_nx = st_idle;
            end
        endcase
    end

    // sram word joins its markers here
    always_comb begin
        beat_nx = mark_q;
        beat_nx.weights = rdata;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= st_idle;
            layer_cnt <= '0;
            line_cnt <= '0;
            idle <= 1'b1;
            mark_q <= '0;
            beat <= '0;
        end else begin
            state <= state_nx;
            layer_cnt <= layer_nx;
            line_cnt <= line_nx;
            idle <= idle_nx;
            mark_q <= rd_mark;
            beat <= beat_nx;
        end
    end

endmodule

/* verilog/weight_sram.sv */
`timescale 1ns/1ps

module weight_sram
    import gnn_weight_pkg::*;
(
    input  logic         clk,
    input  sram_req_t    req,
    output weight_word_t rdata
);

    // address is {layer, line}
    weight_word_t mem [sram_depth];

    // one port: write when cen and wen are low, registered read when only cen is low
    always_ff @(posedge clk) begin
        if (!req.cen) begin
            if (!req.wen) begin
                mem[req.addr] <= req.wdata;
            end else begin
                rdata <= mem[req.addr];
            end
        end
    end

    // rdata keeps the last read word while the port is unused

endmodule

/* verilog/gnn_weight_pkg.sv */
package gnn_weight_pkg;

    // datapath sizing
    localparam int mult_per_pe = 2;
    localparam int fv_size = 8;
    localparam int max_fv_num = 16;
    localparam int max_num_weight_layer = 4;
    localparam int lines_per_layer = max_fv_num / mult_per_pe;
    localparam int sram_aw = 5;
    localparam int acc_w = 20;

    // derived widths
    localparam int word_w = mult_per_pe * fv_size;
    localparam int layer_w = $clog2(max_num_weight_layer);
    localparam int line_w = $clog2(lines_per_layer);
    localparam int fv_idx_w = $clog2(max_fv_num);
    localparam int sram_depth = 1 << sram_aw;

    // one sram line, loaded as raw bits and read back as a weight pair
    // weight 0 sits in the low byte
    typedef union packed {
        logic [word_w-1:0] raw;
        logic [mult_per_pe-1:0][fv_size-1:0] w;
    } weight_word_t;

    // single-port sram request, enables active low
    typedef struct packed {
        logic cen;
        logic wen;
        logic [sram_aw-1:0] addr;
        weight_word_t wdata;
    } sram_req_t;

    // one weight pair with its stream markers
    typedef struct packed {
        logic valid;
        logic sos;
        logic eos;
        logic change;
        logic [fv_idx_w-1:0] fv_idx;
        weight_word_t weights;
    } weight_beat_t;

    typedef struct packed {
        logic [layer_w-1:0] num_layer_m1;
        logic [fv_idx_w:0] num_fv;
    } run_cfg_t;

    typedef struct packed {
        logic [layer_w-1:0] layer;
        logic [acc_w-1:0] sum;
    } layer_result_t;

    typedef logic [max_fv_num-1:0][fv_size-1:0] feature_vec_t;

endpackage
